//--- verilog/centipede_pkg.sv
`default_nettype none

package centipede_pkg;

   // 1 KB regions, selected by address bits 13 to 10
   typedef enum logic [3:0] {
      rgn_ram      = 4'd0,
      rgn_pf       = 4'd1,
      rgn_sw       = 4'd2,
      rgn_in       = 4'd3,
      rgn_pokey    = 4'd4,
      rgn_coloram  = 4'd5,
      rgn_irqres   = 4'd6,
      rgn_out0     = 4'd7,
      rgn_watchdog = 4'd8,
      rgn_steerclr = 4'd9
   } region_e;

   // region plus offset inside the 1 KB window
   typedef struct packed {
      region_e    region;
      logic [9:0] offset;
   } map_view_t;

   // the output latch only looks at the low three address bits
   typedef struct packed {
      region_e    region;
      logic [6:0] spare;
      logic [2:0] bit_idx;
   } latch_view_t;

   typedef union packed {
      map_view_t   map;
      latch_view_t latch;
   } cpu_addr_u;

   typedef logic [7:0] byte_t;
   typedef logic [3:0] nibble_t;

   // horizontal counts in pixels
   localparam int H_TOTAL       = 384;
   localparam int H_BLANK_START = 256;
   localparam int H_SYNC_START  = 288;
   localparam int H_SYNC_END    = 320;

   // vertical counts in lines
   localparam int V_TOTAL       = 256;
   localparam int V_BLANK_START = 240;
   localparam int V_SYNC_START  = 244;
   localparam int V_SYNC_END    = 248;

   // interrupt set and cleared by line number within each 64 line block
   localparam int IRQ_SET_LINE  = 48;
   localparam int IRQ_CLR_LINE  = 16;
   localparam int IRQ_PERIOD    = 64;

endpackage

`default_nettype wire

//--- verilog/cpu_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

interface cpu_bus_if;

   // address and write data as seen on the bus
   centipede_pkg::cpu_addr_u addr;
   centipede_pkg::byte_t     wdata;

   // read selects, only high while rd_i is high
   logic                     sw_rd_sel;
   logic                     in_rd_sel;

   // write strobes, one cycle each
   logic                     color_we;
   logic                     out_we;
   logic                     steer_clr;
   logic                     irq_ack;

   // read data back to the decoder
   centipede_pkg::byte_t     panel_rdata;
   centipede_pkg::nibble_t   color_rdata;

   modport dec (
      output addr, wdata, sw_rd_sel, in_rd_sel, color_we, out_we, steer_clr, irq_ack,
      input  panel_rdata, color_rdata
   );

   modport panel (
      input  addr, wdata, sw_rd_sel, in_rd_sel, out_we, steer_clr,
      output panel_rdata
   );

   modport color (
      input  addr, wdata, color_we,
      output color_rdata
   );

   modport timing (
      input  irq_ack
   );

endinterface

`default_nettype wire

//--- verilog/addr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module addr_decoder (
   input  logic                     s_6mhz,
   input  logic                     reset,
   input  centipede_pkg::cpu_addr_u addr_i,
   input  centipede_pkg::byte_t     wdata_i,
   input  logic                     wr_i,
   input  logic                     rd_i,
   output centipede_pkg::byte_t     rdata_o,
   cpu_bus_if.dec                   bus
);

   centipede_pkg::region_e region;
   logic                   color_hit;
   centipede_pkg::byte_t   rd_mux;

   // region comes from the top four address bits
   assign region = addr_i.map.region;

   // upper half of the colour window was the earom, now dropped
   assign color_hit = (region == centipede_pkg::rgn_coloram) && !addr_i.map.offset[9];

   // address and data go straight to the datapaths
   assign bus.addr  = addr_i;
   assign bus.wdata = wdata_i;

   // read selects steer the panel read mux
   assign bus.sw_rd_sel = rd_i && (region == centipede_pkg::rgn_sw);
   assign bus.in_rd_sel = rd_i && (region == centipede_pkg::rgn_in);

   // write strobes act at the edge where wr_i is sampled
   assign bus.color_we  = wr_i && color_hit;
   assign bus.out_we    = wr_i && (region == centipede_pkg::rgn_out0);
   assign bus.steer_clr = wr_i && (region == centipede_pkg::rgn_steerclr);
   assign bus.irq_ack   = wr_i && (region == centipede_pkg::rgn_irqres);

   // read source by region
   always_comb
   begin
      case (region)
         centipede_pkg::rgn_sw,
         centipede_pkg::rgn_in:
         begin
            rd_mux = bus.panel_rdata;
         end
         centipede_pkg::rgn_coloram:
         begin
            // colour nibble, zero extended
            rd_mux = color_hit ? {4'h0, bus.color_rdata} : 8'h00;
         end
         default:
         begin
            // ram, pf, pokey and the write only regions read as zero
            rd_mux = 8'h00;
         end
      endcase
   end

   // read data shows one edge after rd_i and holds until the next read
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         rdata_o <= 8'h00;
      end
      else if (rd_i)
      begin
         rdata_o <= rd_mux;
      end
   end

   // the bus master never reads and writes in the same cycle
   a_no_rd_wr : assert property (@(posedge s_6mhz) disable iff (reset) !(rd_i && wr_i));

endmodule

`default_nettype wire

//--- verilog/video_timing.sv
`timescale 1ns/100ps
`default_nettype none

module video_timing (
   input  logic      s_6mhz,
   input  logic      reset,
   cpu_bus_if.timing bus,
   output logic      hsync_o,
   output logic      vsync_o,
   output logic      sync_o,
   output logic      hblank_o,
   output logic      vblank_o,
   output logic      irq_o
);

   localparam int H_W = $clog2(centipede_pkg::H_TOTAL);
   localparam int V_W = $clog2(centipede_pkg::V_TOTAL);

   logic [H_W-1:0] h_cnt;
   logic [V_W-1:0] v_cnt;
   logic           h_wrap;
   logic           line_start;
   logic           irq_set;
   logic           irq_clr;

   assign h_wrap     = (h_cnt == H_W'(centipede_pkg::H_TOTAL - 1));
   assign line_start = (h_cnt == '0);

   // line rule, checked at the first pixel of each line
   assign irq_set = line_start &&
                    ((v_cnt % centipede_pkg::IRQ_PERIOD) == centipede_pkg::IRQ_SET_LINE);
   assign irq_clr = line_start &&
                    ((v_cnt % centipede_pkg::IRQ_PERIOD) == centipede_pkg::IRQ_CLR_LINE);

   // pixel counter steps every cycle, line counter on pixel wrap
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         h_cnt <= '0;
         v_cnt <= '0;
      end
      else
      begin
         h_cnt <= h_wrap ? '0 : h_cnt + 1'b1;
         if (h_wrap)
         begin
            // 256 lines so the line counter wraps by itself
            v_cnt <= (v_cnt == V_W'(centipede_pkg::V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
         end
      end
   end

   // registered compares, one cycle behind the counters
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         hblank_o <= 1'b0;
         hsync_o  <= 1'b0;
         vblank_o <= 1'b0;
         vsync_o  <= 1'b0;
      end
      else
      begin
         hblank_o <= (h_cnt >= centipede_pkg::H_BLANK_START);
         hsync_o  <= (h_cnt >= centipede_pkg::H_SYNC_START) &&
                     (h_cnt <  centipede_pkg::H_SYNC_END);
         vblank_o <= (v_cnt >= centipede_pkg::V_BLANK_START);
         vsync_o  <= (v_cnt >= centipede_pkg::V_SYNC_START) &&
                     (v_cnt <  centipede_pkg::V_SYNC_END);
      end
   end

   // composite sync, active high
   assign sync_o = hsync_o | vsync_o;

   // interrupt flop, clear wins over set
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         irq_o <= 1'b0;
      end
      else if (irq_clr || bus.irq_ack)
      begin
         irq_o <= 1'b0;
      end
      else if (irq_set)
      begin
         irq_o <= 1'b1;
      end
   end

   // horizontal sync sits inside horizontal blank
   a_hsync_in_blank : assert property (@(posedge s_6mhz) disable iff (reset)
                                       hsync_o |-> hblank_o);

endmodule

`default_nettype wire

//--- verilog/control_panel.sv
`timescale 1ns/100ps
`default_nettype none

module control_panel #(
   parameter int SYNC_STAGES = 2
) (
   input  logic                 s_6mhz,
   input  logic                 reset,
   cpu_bus_if.panel             bus,
   input  logic                 vblank_i,
   input  logic [9:0]           playerinput_i,
   input  centipede_pkg::byte_t trakball_i,
   input  centipede_pkg::byte_t joystick_i,
   input  centipede_pkg::byte_t sw1_i,
   input  centipede_pkg::byte_t sw2_i,
   output logic [4:1]           led_o,
   output logic [2:0]           coin_ctr_o,
   output logic                 flip_o
);

   logic [7:0]             out_latch;
   logic [3:0]             tb_sel;
   logic [1:0]             axis_ck;
   logic [1:0]             axis_dir;
   logic [1:0]             tb_dir;
   centipede_pkg::nibble_t tb_cnt [2];
   centipede_pkg::byte_t   sw_word;
   centipede_pkg::byte_t   in0_word;
   centipede_pkg::byte_t   in1_word;
   centipede_pkg::byte_t   in_word;

   // addressable latch, data bit 7 goes to the bit picked by the address
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         out_latch <= 8'h00;
      end
      else if (bus.out_we)
      begin
         out_latch[bus.addr.latch.bit_idx] <= bus.wdata[7];
      end
   end

   assign flip_o     = out_latch[7];
   assign led_o      = out_latch[6:3];
   // right, centre, left
   assign coin_ctr_o = out_latch[2:0];

   // flip picks player 1, else player 2
   // order is h dir, h clock, v dir, v clock
   assign tb_sel = flip_o ? {trakball_i[7], trakball_i[5], trakball_i[3], trakball_i[1]} :
                            {trakball_i[6], trakball_i[4], trakball_i[2], trakball_i[0]};

   // axis 1 is horizontal, axis 0 vertical
   assign axis_dir = {tb_sel[3], tb_sel[1]};
   assign axis_ck  = {tb_sel[2], tb_sel[0]};

   for (genvar ax = 0; ax < 2; ax++)
   begin : g_axis
      logic [SYNC_STAGES-1:0] ck_sync;
      logic [SYNC_STAGES-1:0] dir_sync;
      logic                   ck_prev;
      logic                   ck_rise;
      logic                   dir_q;
      centipede_pkg::nibble_t cnt;

      // clock and direction go through the same synchronizer depth
      assign ck_rise = ck_sync[SYNC_STAGES-1] & ~ck_prev;

      always_ff @(posedge s_6mhz or posedge reset)
      begin
         if (reset)
         begin
            ck_sync  <= '0;
            dir_sync <= '0;
            ck_prev  <= 1'b0;
            dir_q    <= 1'b0;
            cnt      <= '0;
         end
         else
         begin
            ck_sync  <= (ck_sync << 1) | SYNC_STAGES'(axis_ck[ax]);
            dir_sync <= (dir_sync << 1) | SYNC_STAGES'(axis_dir[ax]);
            ck_prev  <= ck_sync[SYNC_STAGES-1];
            // step by the direction seen at the last clock edge
            if (bus.steer_clr)
            begin
               cnt <= '0;
            end
            else if (ck_rise)
            begin
               cnt <= dir_q ? cnt + 1'b1 : cnt - 1'b1;
            end
            if (ck_rise)
            begin
               dir_q <= dir_sync[SYNC_STAGES-1];
            end
         end
      end

      assign tb_cnt[ax] = cnt;
      assign tb_dir[ax] = dir_q;
   end

   // option switches, address bit 0 picks bank 2
   assign sw_word = bus.addr.map.offset[0] ? sw2_i : sw1_i;

   // in0, coins are forced by their counter drives
   assign in0_word = bus.addr.map.offset[0] ?
                     {playerinput_i[9] | coin_ctr_o[2],
                      playerinput_i[8] | coin_ctr_o[1],
                      playerinput_i[7] | coin_ctr_o[0],
                      playerinput_i[4], playerinput_i[1], playerinput_i[0],
                      playerinput_i[3], playerinput_i[2]} :
                     {tb_dir[1], vblank_i, playerinput_i[6], playerinput_i[5], tb_cnt[1]};

   // in1, joystick or vertical trackball
   assign in1_word = bus.addr.map.offset[0] ? joystick_i : {tb_dir[0], 3'b000, tb_cnt[0]};

   // address bit 1 picks in1
   assign in_word = bus.addr.map.offset[1] ? in1_word : in0_word;

   assign bus.panel_rdata = bus.sw_rd_sel ? sw_word :
                            bus.in_rd_sel ? in_word : 8'h00;

endmodule

`default_nettype wire

//--- verilog/color_ram.sv
`timescale 1ns/100ps
`default_nettype none

module color_ram (
   input  logic    s_6mhz,
   cpu_bus_if.color bus
);

   // 16 entries of 4 bit colour
   centipede_pkg::nibble_t mem [16];
   logic [3:0]             idx;

   // low four offset bits select the entry
   assign idx = bus.addr.map.offset[3:0];

   always_ff @(posedge s_6mhz)
   begin
      if (bus.color_we)
      begin
         mem[idx] <= bus.wdata[3:0];
      end
   end

   // readback is asynchronous, decoder registers it
   assign bus.color_rdata = mem[idx];

endmodule

`default_nettype wire

//--- verilog/centipede_io.sv
`timescale 1ns/100ps
`default_nettype none

module centipede_io #(
   parameter int SYNC_STAGES = 2
) (
   input  logic        s_6mhz,
   input  logic        reset,
   // bus master side
   input  logic [13:0] addr_i,
   input  logic [7:0]  wdata_i,
   input  logic        wr_i,
   input  logic        rd_i,
   output logic [7:0]  rdata_o,
   // cabinet inputs
   input  logic [9:0]  playerinput_i,
   input  logic [7:0]  trakball_i,
   input  logic [7:0]  joystick_i,
   input  logic [7:0]  sw1_i,
   input  logic [7:0]  sw2_i,
   // latch outputs
   output logic [4:1]  led_o,
   output logic [2:0]  coin_ctr_o,
   output logic        flip_o,
   // video timing
   output logic        hsync_o,
   output logic        vsync_o,
   output logic        sync_o,
   output logic        hblank_o,
   output logic        vblank_o,
   output logic        irq_o
);

   cpu_bus_if bus ();

   addr_decoder u_addr_decoder (
      .s_6mhz  (s_6mhz),
      .reset   (reset),
      .addr_i  (addr_i),
      .wdata_i (wdata_i),
      .wr_i    (wr_i),
      .rd_i    (rd_i),
      .rdata_o (rdata_o),
      .bus     (bus)
   );

   video_timing u_video_timing (
      .s_6mhz   (s_6mhz),
      .reset    (reset),
      .bus      (bus),
      .hsync_o  (hsync_o),
      .vsync_o  (vsync_o),
      .sync_o   (sync_o),
      .hblank_o (hblank_o),
      .vblank_o (vblank_o),
      .irq_o    (irq_o)
   );

   // vblank is also readable through in0
   control_panel #(
      .SYNC_STAGES (SYNC_STAGES)
   ) u_control_panel (
      .s_6mhz        (s_6mhz),
      .reset         (reset),
      .bus           (bus),
      .vblank_i      (vblank_o),
      .playerinput_i (playerinput_i),
      .trakball_i    (trakball_i),
      .joystick_i    (joystick_i),
      .sw1_i         (sw1_i),
      .sw2_i         (sw2_i),
      .led_o         (led_o),
      .coin_ctr_o    (coin_ctr_o),
      .flip_o        (flip_o)
   );

   color_ram u_color_ram (
      .s_6mhz (s_6mhz),
      .bus    (bus)
   );

endmodule

`default_nettype wire

//--- tb/tb_centipede.sv
`timescale 1ns/100ps
`default_nettype none

module tb_centipede;

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 8;
   // loop counts per test
   localparam int N_SW        = 32;
   localparam int N_DROP      = 24;
   localparam int N_IN        = 48;
   localparam int N_LATCH     = 32;
   localparam int N_COLOR     = 64;
   localparam int N_TB_ROUNDS = 8;
   localparam int N_TB_STEPS  = 24;
   localparam int N_ACK       = 3;
   // trackball inputs hold longer than the three edge latency
   localparam int STEP_CYCLES  = 4;
   localparam int FRAME_CYCLES = centipede_pkg::H_TOTAL * centipede_pkg::V_TOTAL;
   localparam int BLOCK_CYCLES = centipede_pkg::IRQ_PERIOD * centipede_pkg::H_TOTAL;
   // two cycles budgeted for each bus access
   localparam int BUS_CYCLES = 2 * (N_SW + N_DROP + 2 * N_IN + N_LATCH + 16 + N_COLOR);
   localparam int TRK_CYCLES = N_TB_ROUNDS * ((N_TB_STEPS + 2) * STEP_CYCLES + 16);
   localparam int IRQ_CYCLES = (2 + N_ACK) * (BLOCK_CYCLES + 256);
   localparam int RUN_CYCLES = RESET_CYCLES + BUS_CYCLES + TRK_CYCLES + FRAME_CYCLES +
                               IRQ_CYCLES + 1000;

   logic                   s_6mhz;
   logic                   reset;
   logic [13:0]            addr_i;
   centipede_pkg::byte_t   wdata_i;
   logic                   wr_i;
   logic                   rd_i;
   centipede_pkg::byte_t   rdata_o;
   logic [9:0]             playerinput_i;
   centipede_pkg::byte_t   trakball_i;
   centipede_pkg::byte_t   joystick_i;
   centipede_pkg::byte_t   sw1_i;
   centipede_pkg::byte_t   sw2_i;
   logic [4:1]             led_o;
   logic [2:0]             coin_ctr_o;
   logic                   flip_o;
   logic                   hsync_o;
   logic                   vsync_o;
   logic                   sync_o;
   logic                   hblank_o;
   logic                   vblank_o;
   logic                   irq_o;

   // random source
   logic [31:0]            lfsr;
   // model of latch, colour RAM and trackball, axis 1 horizontal
   logic [7:0]             m_latch;
   centipede_pkg::nibble_t m_color [16];
   centipede_pkg::nibble_t m_cnt [2];
   logic [1:0]             m_dir;
   logic [1:0]             m_ck;
   // model of the video counters and the registered outputs
   int                     m_h;
   int                     m_v;
   logic                   m_hb;
   logic                   m_hs;
   logic                   m_vb;
   logic                   m_vs;
   logic                   m_irq;
   string                  test_name;
   int                     err_cnt;

   centipede_io u_centipede_io (
      .s_6mhz        (s_6mhz),
      .reset         (reset),
      .addr_i        (addr_i),
      .wdata_i       (wdata_i),
      .wr_i          (wr_i),
      .rd_i          (rd_i),
      .rdata_o       (rdata_o),
      .playerinput_i (playerinput_i),
      .trakball_i    (trakball_i),
      .joystick_i    (joystick_i),
      .sw1_i         (sw1_i),
      .sw2_i         (sw2_i),
      .led_o         (led_o),
      .coin_ctr_o    (coin_ctr_o),
      .flip_o        (flip_o),
      .hsync_o       (hsync_o),
      .vsync_o       (vsync_o),
      .sync_o        (sync_o),
      .hblank_o      (hblank_o),
      .vblank_o      (vblank_o),
      .irq_o         (irq_o)
   );

   initial
   begin
      s_6mhz = 1'b0;
      forever #(CLK_PERIOD / 2) s_6mhz = ~s_6mhz;
   end

   // galois lfsr, one step per bit handed out
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic logic [13:0] addr_of(input logic [3:0] rgn, input logic [9:0] off);
      return {rgn, off};
   endfunction

   // player inputs: 9..7 coin r c l, 6 self test, 5 cocktail, 4 slam,
   // 3 start1, 2 start2, 1 fire2, 0 fire1
   function automatic centipede_pkg::byte_t expect_in(input logic [9:0] off);
      centipede_pkg::byte_t w;
      logic [9:0]           pi;
      pi = playerinput_i;
      if (off[1] && off[0])
      begin
         w = joystick_i;
      end
      else if (off[1])
      begin
         w = {m_dir[0], 3'b000, m_cnt[0]};
      end
      else if (off[0])
      begin
         // coin drives read back as coins
         w = {pi[9] | m_latch[2], pi[8] | m_latch[1], pi[7] | m_latch[0],
              pi[4], pi[1], pi[0], pi[3], pi[2]};
      end
      else
      begin
         w = {m_dir[1], m_vb, pi[6], pi[5], m_cnt[1]};
      end
      return w;
   endfunction

   task automatic stop_run();
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_byte(input string name, input centipede_pkg::byte_t exp,
                             input centipede_pkg::byte_t act);
      if (act !== exp)
      begin
         err_cnt++;
         $display("ERROR %s %s: expected %h, actual %h", test_name, name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_nibble(input string name, input centipede_pkg::nibble_t exp,
                               input centipede_pkg::nibble_t act);
      if (act !== exp)
      begin
         err_cnt++;
         $display("ERROR %s %s: expected %h, actual %h", test_name, name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         err_cnt++;
         $display("ERROR %s %s: expected %b, actual %b", test_name, name, exp, act);
         stop_run();
      end
   endtask

   // one cycle write, starts and ends on a falling edge
   task automatic bus_write(input logic [13:0] a, input centipede_pkg::byte_t d);
      addr_i  = a;
      wdata_i = d;
      wr_i    = 1'b1;
      @(negedge s_6mhz);
      wr_i    = 1'b0;
   endtask

   // data is captured at the rising edge and held by the next falling edge
   task automatic bus_read(input logic [13:0] a, output centipede_pkg::byte_t d);
      addr_i = a;
      rd_i   = 1'b1;
      @(negedge s_6mhz);
      rd_i   = 1'b0;
      d      = rdata_o;
   endtask

   // count on a rising clock by the direction kept from the last rise
   task automatic step_axis(input int ax, input logic ck, input logic dir);
      if (ck && !m_ck[ax])
      begin
         m_cnt[ax] = m_dir[ax] ? m_cnt[ax] + 4'd1 : m_cnt[ax] - 4'd1;
         m_dir[ax] = dir;
      end
      m_ck[ax] = ck;
   endtask

   task automatic drive_trakball(input centipede_pkg::byte_t tb);
      logic sel;
      // flip picks player 1 on the odd bits
      sel = m_latch[7];
      step_axis(1, tb[4 + sel], tb[6 + sel]);
      step_axis(0, tb[sel], tb[2 + sel]);
      trakball_i = tb;
      repeat (STEP_CYCLES) @(negedge s_6mhz);
   endtask

   task automatic check_counts();
      centipede_pkg::byte_t rd;
      bus_read(addr_of(centipede_pkg::rgn_in, 10'h000), rd);
      check_nibble("h_count", m_cnt[1], rd[3:0]);
      check_bit("h_dir", m_dir[1], rd[7]);
      bus_read(addr_of(centipede_pkg::rgn_in, 10'h002), rd);
      check_nibble("v_count", m_cnt[0], rd[3:0]);
      check_bit("v_dir", m_dir[0], rd[7]);
   endtask

   task automatic wait_irq(input logic level, input int max_cycles);
      int n;
      n = 0;
      while (irq_o !== level && n < max_cycles)
      begin
         @(negedge s_6mhz);
         n++;
      end
      if (irq_o !== level)
      begin
         $display("irq_o did not reach %b within %0d cycles", level, max_cycles);
         stop_run();
      end
   endtask

   // video model, counts from reset release
   always @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         m_h   <= 0;
         m_v   <= 0;
         m_hb  <= 1'b0;
         m_hs  <= 1'b0;
         m_vb  <= 1'b0;
         m_vs  <= 1'b0;
         m_irq <= 1'b0;
      end
      else
      begin
         // outputs show last cycle's count
         m_hb <= (m_h >= centipede_pkg::H_BLANK_START);
         m_hs <= (m_h >= centipede_pkg::H_SYNC_START) && (m_h < centipede_pkg::H_SYNC_END);
         m_vb <= (m_v >= centipede_pkg::V_BLANK_START);
         m_vs <= (m_v >= centipede_pkg::V_SYNC_START) && (m_v < centipede_pkg::V_SYNC_END);
         // ack write or clear line drops irq, set line raises it
         if ((wr_i && addr_i[13:10] == centipede_pkg::rgn_irqres) ||
             (m_h == 0 && (m_v % centipede_pkg::IRQ_PERIOD) == centipede_pkg::IRQ_CLR_LINE))
         begin
            m_irq <= 1'b0;
         end
         else if (m_h == 0 && (m_v % centipede_pkg::IRQ_PERIOD) == centipede_pkg::IRQ_SET_LINE)
         begin
            m_irq <= 1'b1;
         end
         if (m_h == centipede_pkg::H_TOTAL - 1)
         begin
            m_h <= 0;
            m_v <= (m_v + 1) % centipede_pkg::V_TOTAL;
         end
         else
         begin
            m_h <= m_h + 1;
         end
      end
   end

   // video and irq outputs checked on every falling edge
   always @(negedge s_6mhz)
   begin
      if (!reset)
      begin
         check_bit("hsync", m_hs, hsync_o);
         check_bit("hblank", m_hb, hblank_o);
         check_bit("vsync", m_vs, vsync_o);
         check_bit("vblank", m_vb, vblank_o);
         check_bit("sync", m_hs | m_vs, sync_o);
         check_bit("irq", m_irq, irq_o);
      end
   end

   initial
   begin
      #(RUN_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the run hung", RUN_CYCLES);
      stop_run();
   end

   initial
   begin
      centipede_pkg::byte_t rd;
      centipede_pkg::byte_t exp_w;
      centipede_pkg::byte_t d;
      logic [9:0]           off;
      logic [3:0]           rgn;
      logic [2:0]           idx;
      logic                 flip;
      logic                 vb;
      lfsr          = 32'haea21639;
      err_cnt       = 0;
      test_name     = "reset";
      reset         = 1'b1;
      addr_i        = '0;
      wdata_i       = '0;
      wr_i          = 1'b0;
      rd_i          = 1'b0;
      playerinput_i = '0;
      trakball_i    = '0;
      joystick_i    = '0;
      sw1_i         = '0;
      sw2_i         = '0;
      m_latch       = '0;
      m_cnt[0]      = '0;
      m_cnt[1]      = '0;
      m_dir         = '0;
      m_ck          = '0;
      repeat (RESET_CYCLES) @(posedge s_6mhz);
      @(negedge s_6mhz);
      reset = 1'b0;

      // option switches, bit 0 picks sw2
      test_name = "switches";
      for (int i = 0; i < N_SW; i++)
      begin
         sw1_i = 8'(rand_bits(8));
         sw2_i = 8'(rand_bits(8));
         off   = 10'(rand_bits(10));
         bus_read(addr_of(centipede_pkg::rgn_sw, off), rd);
         check_byte("sw", off[0] ? sw2_i : sw1_i, rd);
      end

      test_name = "dropped";
      for (int i = 0; i < N_DROP; i++)
      begin
         rgn = 4'(rand_bits(4));
         off = 10'(rand_bits(10));
         // live regions swap for the upper colour window, which is gone
         if (rgn == centipede_pkg::rgn_sw || rgn == centipede_pkg::rgn_in ||
             rgn == centipede_pkg::rgn_coloram)
         begin
            rgn    = centipede_pkg::rgn_coloram;
            off[9] = 1'b1;
         end
         bus_read(addr_of(rgn, off), rd);
         check_byte("read", 8'h00, rd);
      end

      test_name = "inputs";
      for (int i = 0; i < N_IN; i++)
      begin
         playerinput_i = 10'(rand_bits(10));
         joystick_i    = 8'(rand_bits(8));
         // sometimes move a coin drive, index 3 means leave the latch alone
         idx = 3'(rand_bits(2));
         if (idx != 3'd3)
         begin
            d = 8'(rand_bits(8));
            bus_write(addr_of(centipede_pkg::rgn_out0, {7'(rand_bits(7)), idx}), d);
            m_latch[idx] = d[7];
         end
         off   = 10'(rand_bits(10));
         exp_w = expect_in(off);
         bus_read(addr_of(centipede_pkg::rgn_in, off), rd);
         check_byte("in", exp_w, rd);
      end

      test_name = "latch";
      for (int i = 0; i < N_LATCH; i++)
      begin
         idx = 3'(rand_bits(3));
         d   = 8'(rand_bits(8));
         bus_write(addr_of(centipede_pkg::rgn_out0, {7'(rand_bits(7)), idx}), d);
         m_latch[idx] = d[7];
         check_nibble("led", m_latch[6:3], led_o);
         check_nibble("coin", {1'b0, m_latch[2:0]}, {1'b0, coin_ctr_o});
         check_bit("flip", m_latch[7], flip_o);
      end

      // fill every colour entry first, the RAM has no reset
      test_name = "color";
      for (int i = 0; i < 16; i++)
      begin
         d = 8'(rand_bits(8));
         bus_write(addr_of(centipede_pkg::rgn_coloram, {1'b0, 5'(rand_bits(5)), 4'(i)}), d);
         m_color[i] = d[3:0];
      end
      for (int i = 0; i < N_COLOR; i++)
      begin
         off = 10'(rand_bits(10));
         if (rand_bits(1) == 1)
         begin
            d = 8'(rand_bits(8));
            bus_write(addr_of(centipede_pkg::rgn_coloram, off), d);
            // nothing behind the upper half of the window
            if (!off[9])
            begin
               m_color[off[3:0]] = d[3:0];
            end
         end
         else
         begin
            off[9] = 1'b0;
            bus_read(addr_of(centipede_pkg::rgn_coloram, off), rd);
            check_nibble("color", m_color[off[3:0]], rd[3:0]);
            check_nibble("color_upper", 4'h0, rd[7:4]);
         end
      end

      test_name = "trackball";
      for (int r = 0; r < N_TB_ROUNDS; r++)
      begin
         // both clocks low so the player swap makes no edge
         drive_trakball(8'h00);
         flip = 1'(rand_bits(1));
         bus_write(addr_of(centipede_pkg::rgn_out0, {7'(rand_bits(7)), 3'd7}),
                   {flip, 7'(rand_bits(7))});
         m_latch[7] = flip;
         for (int s = 0; s < N_TB_STEPS; s++)
         begin
            drive_trakball(8'(rand_bits(8)));
         end
         check_counts();
         if (rand_bits(1) == 1 || r == N_TB_ROUNDS - 1)
         begin
            bus_write(addr_of(centipede_pkg::rgn_steerclr, 10'(rand_bits(10))),
                      8'(rand_bits(8)));
            // clear leaves the directions alone
            m_cnt[0] = '0;
            m_cnt[1] = '0;
            check_counts();
         end
      end

      // the falling edge checker covers every cycle of the frame
      // in0 is read every cycle so its vblank bit is seen at both levels
      test_name = "video";
      for (int i = 0; i < FRAME_CYCLES; i++)
      begin
         vb = m_vb;
         bus_read(addr_of(centipede_pkg::rgn_in, 10'h000), rd);
         check_bit("in0_vblank", vb, rd[6]);
      end

      test_name = "irq";
      wait_irq(1'b1, BLOCK_CYCLES + 256);
      wait_irq(1'b0, BLOCK_CYCLES + 256);
      for (int k = 0; k < N_ACK; k++)
      begin
         wait_irq(1'b1, BLOCK_CYCLES + 256);
         // ack somewhere early in the high window
         repeat (8'(rand_bits(8))) @(negedge s_6mhz);
         bus_write(addr_of(centipede_pkg::rgn_irqres, 10'(rand_bits(10))), 8'(rand_bits(8)));
         check_bit("irq_ack", 1'b0, irq_o);
      end

      if (err_cnt == 0)
      begin
         $display("TEST OK");
         $finish;
      end
      else
      begin
         stop_run();
      end
   end

endmodule

`default_nettype wire

//--- all.f
verilog/centipede_pkg.sv
verilog/cpu_bus_if.sv
verilog/addr_decoder.sv
verilog/video_timing.sv
verilog/control_panel.sv
verilog/color_ram.sv
verilog/centipede_io.sv
tb/tb_centipede.sv

//--- Makefile
SRCS := $(shell cat all.f)

obj_dir/Vtb_centipede: all.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_centipede -f all.f -o Vtb_centipede

run: obj_dir/Vtb_centipede
	@out="$$(./obj_dir/Vtb_centipede)"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf obj_dir

.PHONY: run clean
